// File: sources.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/pipeReg.sv
hw/forwardUnit.sv
hw/execUnit.sv
hw/exStage.sv
bench/exStage_chk.sv
bench/exStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module exStageTb \
    -f sources.f --Mdir obj_dir -o exStageSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/exStageSim > sim.log 2>&1
cat sim.log

grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: bench/exStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module exStageTb
    import isaPkg::*, pipePkg::*;
();

    logic     clk;
    logic     rstN;
    logic     stall;
    logic     flush;
    idExT     decodeIn;
    fwdSrcT   wbFwd;
    exMemT    exMemOut;
    redirectT redirect;

    idExT     mIdEx;                            // Model of the ID/EX register.
    exMemT    mExMem;                           // Model of the EX/MEM register.
    integer   seed = 32'h6a22_7368;
    logic     rstDrive;
    logic     timedOut;
    int       errCount;
    int       checks;
    int       testErrBase;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    exStage exStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .flush    (flush),
        .decodeIn (decodeIn),
        .wbFwd    (wbFwd),
        .exMemOut (exMemOut),
        .redirect (redirect)
    );

    bind exStage exStageChk exStageChk_i (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .idExQ   (idExQ),
        .exValid (exMemOut.valid),
        .taken   (redirect.taken)
    );

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    // Small register indices in dep mode so that dependencies are frequent.
    function automatic idExT randomBundle(input logic dep, input logic br, input logic hiLo);
        idExT        b;
        logic [31:0] r;
        logic [31:0] regs;
        logic [31:0] imm;
        r = nextRand();
        regs = nextRand();
        imm = nextRand();
        b.valid = (r[2:0] != 3'd0);
        b.pc = nextRand() & 32'hffff_fffc;
        b.pcPlus4 = b.pc + 32'd4;
        b.pcBranch = nextRand() & 32'hffff_fffc;
        b.brCond = br ? brCondT'(r[5:3]) : brNone;
        b.srcA = (r[7:6] == 2'd0) ? 32'd0 : nextRand();
        b.srcB = r[8] ? b.srcA : nextRand();    // Equal operands for eq and ne.
        b.signImm = {{16{imm[15]}}, imm[15:0]};
        b.rs = dep ? {3'd0, regs[1:0]} : regs[4:0];
        b.rt = dep ? {3'd0, regs[9:8]} : regs[12:8];
        b.rd = dep ? {3'd0, regs[17:16]} : regs[20:16];
        b.hiIn = nextRand();
        b.loIn = nextRand();
        b.memToReg = r[10:9];
        b.memWrite = r[11];
        b.aluSrc = r[12];
        b.regDst = r[13];
        b.regWrite = dep | r[14];
        b.aluOp = aluOpT'(r[19:16] % 4'd12);
        b.gprToHi = hiLo & r[20];
        b.gprToLo = hiLo & r[21];
        return b;
    endfunction

    function automatic fwdSrcT randomWb(input logic dep);
        fwdSrcT      w;
        logic [31:0] r;
        r = nextRand();
        w.regWrite = r[0];
        w.dest = dep ? {3'd0, r[2:1]} : r[5:1];
        w.data = nextRand();
        return w;
    endfunction

    // EX/MEM first, then writeback, then the decode read; r0 never bypasses.
    function automatic wordT fwdPick(input regIdxT idx, input wordT readVal);
        if (idx == 5'd0) begin
            return readVal;
        end
        if (mExMem.regWrite && mExMem.dest == idx) begin
            return mExMem.aluResult;
        end
        if (wbFwd.regWrite && wbFwd.dest == idx) begin
            return wbFwd.data;
        end
        return readVal;
    endfunction

    function automatic exMemT modelExec(input idExT c);
        exMemT       r;
        wordT        a;
        wordT        b;
        wordT        bOp;
        wordT        alu;
        logic [4:0]  sh;
        logic [63:0] ext;
        a = fwdPick(c.rs, c.srcA);
        b = fwdPick(c.rt, c.srcB);
        bOp = c.aluSrc ? c.signImm : b;
        sh = c.signImm[10:6];
        ext = {{32{bOp[31]}}, bOp} >> sh;
        case (c.aluOp)
            aluAdd:  alu = a + bOp;
            aluSub:  alu = a + ~bOp + 32'd1;
            aluAnd:  alu = a & bOp;
            aluOr:   alu = a | bOp;
            aluXor:  alu = a ^ bOp;
            aluNor:  alu = ~a & ~bOp;
            aluSlt:  alu = {31'd0, (a[31] != bOp[31]) ? a[31] : (a < bOp)};
            aluSltu: alu = {31'd0, a < bOp};
            aluSll:  alu = bOp << sh;
            aluSrl:  alu = bOp >> sh;
            aluSra:  alu = ext[31:0];
            aluLui:  alu = bOp << 16;
            default: alu = '0;
        endcase
        r.valid = c.valid;
        r.pc = c.pc;
        r.aluResult = alu;
        r.storeData = b;
        r.dest = c.regDst ? c.rd : c.rt;
        r.regWrite = c.valid & c.regWrite;
        r.memToReg = c.memToReg;
        r.memWrite = c.valid & c.memWrite;
        r.hiWrite = c.valid & c.gprToHi;
        r.loWrite = c.valid & c.gprToLo;
        r.hiLoData = a;
        return r;
    endfunction

    function automatic redirectT modelRedirect(input idExT c);
        redirectT rd;
        wordT     a;
        wordT     b;
        logic     cond;
        a = fwdPick(c.rs, c.srcA);
        b = fwdPick(c.rt, c.srcB);
        case (c.brCond)
            brEq:     cond = (a == b);
            brNe:     cond = (a != b);
            brGtz:    cond = ($signed(a) > 32'sd0);
            brLez:    cond = ($signed(a) <= 32'sd0);
            brLtz:    cond = a[31];
            brGez:    cond = !a[31];
            brAlways: cond = 1'b1;
            default:  cond = 1'b0;
        endcase
        rd.taken = c.valid & cond;
        rd.target = (c.brCond == brAlways) ? a : c.pcBranch;
        return rd;
    endfunction

    task automatic modelStep();
        exMemT ex;
        ex = modelExec(mIdEx);                  // Uses the state before this edge.
        if (!rstN) begin
            mIdEx = '0;
            mExMem = '0;
        end else begin
            mExMem = stall ? '0 : ex;
            mIdEx = flush ? '0 : (stall ? mIdEx : decodeIn);
        end
    endtask

    task automatic reportMismatch(input string name, input logic [511:0] exp,
                                  input logic [511:0] act);
        errCount++;
        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic checkOutputs();
        redirectT expRedir;
        expRedir = modelRedirect(mIdEx);
        checks += 3;
        if (exStage_i.idExQ !== mIdEx) begin
            reportMismatch("idExQ", 512'(mIdEx), 512'(exStage_i.idExQ));
        end
        if (exMemOut !== mExMem) reportMismatch("exMemOut", 512'(mExMem), 512'(exMemOut));
        if (redirect !== expRedir) reportMismatch("redirect", 512'(expRedir), 512'(redirect));
    endtask

    // Inputs change right after the edge, outputs are checked at the falling edge.
    task automatic runCycle(input idExT d, input logic st, input logic fl, input fwdSrcT wb);
        @(posedge clk);
        modelStep();
        rstN <= rstDrive;
        decodeIn <= d;
        stall <= st;
        flush <= fl;
        wbFwd <= wb;
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic finishTest(input string name, input int cycles);
        $display("Test %s finished: %0d cycles, %0d errors", name, cycles,
                 errCount - testErrBase);
        testErrBase = errCount;
    endtask

    task automatic resetTest();
        logic [5:0] ctrl;
        for (int i = 0; i < 16; i++) begin
            rstDrive = (i == 15);
            runCycle(randomBundle(1'b0, 1'b1, 1'b1), 1'b0, 1'b0, randomWb(1'b0));
        end
        ctrl = {exMemOut.valid, exMemOut.regWrite, exMemOut.memWrite,
                exMemOut.hiWrite, exMemOut.loWrite, redirect.taken};
        checks++;
        if (ctrl !== 6'd0) reportMismatch("control bits after reset", 512'd0, 512'(ctrl));
        finishTest("reset", 16);
    endtask

    task automatic aluTest();
        idExT probe;
        int   lat;
        runCycle('0, 1'b0, 1'b0, '0);
        runCycle('0, 1'b0, 1'b0, '0);
        probe = randomBundle(1'b0, 1'b0, 1'b0);
        probe.valid = 1'b1;
        runCycle(probe, 1'b0, 1'b0, '0);
        lat = 0;
        do begin
            runCycle('0, 1'b0, 1'b0, '0);
            lat++;
        end while (!exMemOut.valid && lat < 8);
        if (!exMemOut.valid) begin
            timedOut = 1'b1;
            $display("Timeout: no valid result on exMemOut within 8 cycles of acceptance");
        end else begin
            checks++;
            if (lat != 2) reportMismatch("result latency", 512'd2, 512'(lat));
            for (int i = 0; i < 200; i++) begin
                runCycle(randomBundle(1'b0, 1'b0, 1'b0), 1'b0, 1'b0, randomWb(1'b0));
            end
        end
        finishTest("alu", 203 + lat);
    endtask

    task automatic streamTest(input string name, input logic br, input logic hiLo);
        for (int i = 0; i < 200; i++) begin
            runCycle(randomBundle(1'b1, br, hiLo), 1'b0, 1'b0, randomWb(1'b1));
        end
        finishTest(name, 200);
    endtask

    task automatic stallFlushTest();
        logic [31:0] r;
        idExT        b;
        idExT        heldIdEx;
        redirectT    heldRedir;
        for (int i = 0; i < 200; i++) begin
            r = nextRand();
            runCycle(randomBundle(1'b1, 1'b1, 1'b1), r[1:0] == 2'd0, r[4:2] == 3'd0,
                     randomWb(1'b1));
        end
        b = randomBundle(1'b1, 1'b1, 1'b0);
        b.valid = 1'b1;
        b.brCond = brAlways;                    // Taken, so the held redirect is visible.
        runCycle(b, 1'b0, 1'b0, '0);
        runCycle('0, 1'b1, 1'b0, '0);
        runCycle('0, 1'b1, 1'b0, '0);
        heldIdEx = exStage_i.idExQ;
        heldRedir = redirect;
        for (int i = 0; i < 3; i++) begin
            runCycle('0, 1'b1, 1'b0, '0);
            checks += 3;
            if (exStage_i.idExQ !== heldIdEx) begin
                reportMismatch("held idExQ", 512'(heldIdEx), 512'(exStage_i.idExQ));
            end
            if (redirect !== heldRedir) begin
                reportMismatch("held redirect", 512'(heldRedir), 512'(redirect));
            end
            if (exMemOut.valid !== 1'b0) begin
                reportMismatch("bubble valid", 512'd0, 512'(exMemOut.valid));
            end
        end
        runCycle('0, 1'b1, 1'b1, '0);
        runCycle(b, 1'b0, 1'b0, '0);            // Flush beats stall at this edge.
        checks += 2;
        if (exStage_i.idExQ.valid !== 1'b0) begin
            reportMismatch("flushed idExQ.valid", 512'd0, 512'(exStage_i.idExQ.valid));
        end
        if (redirect.taken !== 1'b0) begin
            reportMismatch("flushed redirect.taken", 512'd0, 512'(redirect.taken));
        end
        finishTest("stallFlush", 208);
    endtask

    initial begin
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        decodeIn = '0;
        wbFwd = '0;
        mIdEx = '0;
        mExMem = '0;
        rstDrive = 1'b0;
        timedOut = 1'b0;
        errCount = 0;
        checks = 0;
        testErrBase = 0;
        resetTest();
        aluTest();
        if (!timedOut) begin
            streamTest("forward", 1'b0, 1'b0);
            streamTest("branch", 1'b1, 1'b0);
            stallFlushTest();
            streamTest("hiLo", 1'b0, 1'b1);
        end
        $display("Summary: %0d checks, %0d errors", checks, errCount);
        if (timedOut || errCount != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/exStage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exStageChk
    import pipePkg::*;
(
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic flush,
    input idExT idExQ,
    input logic exValid,
    input logic taken
);

    resetClears: assert property (@(posedge clk) !rstN |=> !exValid)
        else $error("EX/MEM valid set right after reset");

    stallHolds: assert property (@(posedge clk) rstN && stall && !flush |=> $stable(idExQ))
        else $error("ID/EX contents changed while stalled");

    flushClears: assert property (@(posedge clk) rstN && flush |=> !idExQ.valid)
        else $error("ID/EX still valid after flush");

    // A redirect only comes from a live instruction.
    redirectLive: assert property (@(posedge clk) taken |-> idExQ.valid)
        else $error("Redirect taken with empty ID/EX");

endmodule

`default_nettype wire

// File: hw/exStage.sv
`timescale 1ns/1ps
`default_nettype none

module exStage
    import isaPkg::*, pipePkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  logic     flush,
    input  idExT     decodeIn,
    input  fwdSrcT   wbFwd,
    output exMemT    exMemOut,
    output redirectT redirect
);

    idExT   idExQ;
    exMemT  exResult;
    fwdSrcT exFwd;
    wordT   opA;
    wordT   opB;

    pipeReg #(
        .payloadT (idExT)
    ) idExReg_i (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (decodeIn),
        .q     (idExQ)
    );

    // Bypass source taken from the registered execute result.
    assign exFwd.regWrite = exMemOut.regWrite;
    assign exFwd.dest     = exMemOut.dest;
    assign exFwd.data     = exMemOut.aluResult;

    forwardUnit forwardUnit_i (
        .rs    (idExQ.rs),
        .rt    (idExQ.rt),
        .readA (idExQ.srcA),
        .readB (idExQ.srcB),
        .exSrc (exFwd),
        .wbSrc (wbFwd),
        .opA   (opA),
        .opB   (opB)
    );

    execUnit execUnit_i (
        .cur      (idExQ),
        .opA      (opA),
        .opB      (opB),
        .result   (exResult),
        .redirect (redirect)
    );

    // A held instruction sends a bubble on instead of a duplicate.
    pipeReg #(
        .payloadT (exMemT)
    ) exMemReg_i (
        .clk   (clk),
        .rstN  (rstN),
        .stall (1'b0),
        .flush (stall),
        .d     (exResult),
        .q     (exMemOut)
    );

endmodule

`default_nettype wire

// File: hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit
    import isaPkg::*, pipePkg::*;
(
    input  idExT     cur,
    input  wordT     opA,
    input  wordT     opB,
    output exMemT    result,
    output redirectT redirect
);

    wordT              aluB;
    logic [shamtW-1:0] shamt;
    wordT              aluOut;
    logic              condMet;
    regIdxT            dest;
    logic              aNeg;
    logic              aZero;

    assign aluB  = cur.aluSrc ? cur.signImm : opB;
    assign shamt = cur.signImm[shamtLsb +: shamtW];
    assign dest  = cur.regDst ? cur.rd : cur.rt;

    always_comb begin
        case (cur.aluOp)
            aluAdd: begin
                aluOut = opA + aluB;
            end
            aluSub: begin
                aluOut = opA - aluB;
            end
            aluAnd: begin
                aluOut = opA & aluB;
            end
            aluOr: begin
                aluOut = opA | aluB;
            end
            aluXor: begin
                aluOut = opA ^ aluB;
            end
            aluNor: begin
                aluOut = ~(opA | aluB);
            end
            aluSlt: begin
                aluOut = wordT'($signed(opA) < $signed(aluB));
            end
            aluSltu: begin
                aluOut = wordT'(opA < aluB);
            end
            aluSll: begin
                aluOut = aluB << shamt;         // Shifts act on operand B.
            end
            aluSrl: begin
                aluOut = aluB >> shamt;
            end
            aluSra: begin
                aluOut = wordT'($signed(aluB) >>> shamt);
            end
            aluLui: begin
                aluOut = {aluB[15:0], 16'h0000};
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

    // Branch judgement on the forwarded operands.
    assign aNeg  = opA[wordW-1];
    assign aZero = (opA == '0);

    always_comb begin
        case (cur.brCond)
            brEq: begin
                condMet = (opA == opB);
            end
            brNe: begin
                condMet = (opA != opB);
            end
            brGtz: begin
                condMet = !aNeg && !aZero;
            end
            brLez: begin
                condMet = aNeg || aZero;
            end
            brLtz: begin
                condMet = aNeg;
            end
            brGez: begin
                condMet = !aNeg;
            end
            brAlways: begin
                condMet = 1'b1;
            end
            default: begin
                condMet = 1'b0;                 // Not a branch.
            end
        endcase
    end

    assign redirect.taken  = cur.valid && condMet;
    assign redirect.target = (cur.brCond == brAlways) ? opA : cur.pcBranch;

    always_comb begin
        result.valid     = cur.valid;
        result.pc        = cur.pc;
        result.aluResult = aluOut;
        result.storeData = opB;                 // Forwarded rt value.
        result.dest      = dest;
        result.regWrite  = cur.valid && cur.regWrite;
        result.memToReg  = cur.memToReg;
        result.memWrite  = cur.valid && cur.memWrite;
        result.hiWrite   = cur.valid && cur.gprToHi;
        result.loWrite   = cur.valid && cur.gprToLo;
        result.hiLoData  = opA;                 // mthi and mtlo move rs.
    end

endmodule

`default_nettype wire

// File: hw/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit
    import isaPkg::*, pipePkg::*;
(
    input  regIdxT rs,
    input  regIdxT rt,
    input  wordT   readA,
    input  wordT   readB,
    input  fwdSrcT exSrc,
    input  fwdSrcT wbSrc,
    output wordT   opA,
    output wordT   opB
);

    // Newest producer first, then writeback, then the decode read.
    function automatic wordT pickOperand(
        input regIdxT idx,
        input wordT   readVal,
        input fwdSrcT ex,
        input fwdSrcT wb
    );
        wordT val;
        val = readVal;
        if (idx != zeroReg) begin
            if (ex.regWrite && ex.dest == idx) begin
                val = ex.data;
            end else if (wb.regWrite && wb.dest == idx) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    assign opA = pickOperand(rs, readA, exSrc, wbSrc);
    assign opB = pickOperand(rt, readB, exSrc, wbSrc);

endmodule

`default_nettype wire

// File: hw/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Flush and reset both empty the stage, flush wins over stall.
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;                            // Valid and all write enables drop.
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: hw/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    // Decode bundle held in the ID/EX register.
    typedef struct packed {
        logic       valid;
        wordT       pc;
        wordT       pcPlus4;
        wordT       pcBranch;
        brCondT     brCond;
        wordT       srcA;                       // Register file read of rs.
        wordT       srcB;                       // Register file read of rt.
        wordT       signImm;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        wordT       hiIn;
        wordT       loIn;
        logic [1:0] memToReg;
        logic       memWrite;
        logic       aluSrc;
        logic       regDst;
        logic       regWrite;
        aluOpT      aluOp;
        logic       gprToHi;
        logic       gprToLo;
    } idExT;

    // Execute result held in the EX/MEM register.
    typedef struct packed {
        logic       valid;
        wordT       pc;
        wordT       aluResult;
        wordT       storeData;
        regIdxT     dest;
        logic       regWrite;
        logic [1:0] memToReg;
        logic       memWrite;
        logic       hiWrite;
        logic       loWrite;
        wordT       hiLoData;
    } exMemT;

    // One bypass source from a later stage.
    typedef struct packed {
        logic   regWrite;
        regIdxT dest;
        wordT   data;
    } fwdSrcT;

    typedef struct packed {
        logic taken;
        wordT target;
    } redirectT;

endpackage

`default_nettype wire

// File: hw/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordW   = 32;                // Data and address width.
    localparam int regIdxW = 5;                 // Register index width.
    localparam int shamtW  = 5;                 // Shift amount width.
    localparam int shamtLsb = 6;                // Shift amount position in the immediate.

    typedef logic [wordW-1:0]   wordT;
    typedef logic [regIdxW-1:0] regIdxT;

    // ALU operation codes, as produced by decode.
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluNor  = 4'd5,
        aluSlt  = 4'd6,
        aluSltu = 4'd7,
        aluSll  = 4'd8,
        aluSrl  = 4'd9,
        aluSra  = 4'd10,
        aluLui  = 4'd11
    } aluOpT;

    // Branch conditions, resolved in execute.
    typedef enum logic [2:0] {
        brNone   = 3'd0,
        brEq     = 3'd1,
        brNe     = 3'd2,
        brGtz    = 3'd3,
        brLez    = 3'd4,
        brLtz    = 3'd5,
        brGez    = 3'd6,
        brAlways = 3'd7                         // Jump register.
    } brCondT;

    localparam regIdxT zeroReg = '0;            // Hardwired zero register.

endpackage

`default_nettype wire
